/* Bender.yml */
package:
  name: emu_core

sources:
  - files:
      - verilog/emu_cfg_pkg.sv
      - verilog/video_pkg.sv
      - verilog/cfg_regs.sv
      - verilog/fb_descriptor.sv
      - verilog/activity_led.sv
      - verilog/gravis_clock.sv
      - verilog/emu_core.sv
  - target: test
    files:
      - dv/emu_core_assert.sv
      - dv/tb_emu_core.sv

/* dv/emu_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module emu_core_assert (
	input logic                       clk_sys,
	input logic                       cpu_reset,
	input emu_cfg_pkg::axi_lite_req_t cfg_req,
	input emu_cfg_pkg::axi_lite_rsp_t cfg_rsp
);

	// ================================================
	// Responses held until taken
	// ================================================

	bvalid_held: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		cfg_rsp.bvalid && !cfg_req.bready |=> cfg_rsp.bvalid)
		else $error("bvalid dropped before bready");

	rvalid_held: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		cfg_rsp.rvalid && !cfg_req.rready |=> cfg_rsp.rvalid)
		else $error("rvalid dropped before rready");

	// Payload stable while stalled
	bresp_stable: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		cfg_rsp.bvalid && !cfg_req.bready |=> $stable(cfg_rsp.bresp))
		else $error("bresp changed while bvalid was stalled");

	rdata_stable: assert property (@(posedge clk_sys) disable iff (cpu_reset)
		cfg_rsp.rvalid && !cfg_req.rready |=> $stable(cfg_rsp.rdata) && $stable(cfg_rsp.rresp))
		else $error("rdata or rresp changed while rvalid was stalled");

	valid_after_reset: assert property (@(posedge clk_sys)
		cpu_reset |=> !cfg_rsp.bvalid && !cfg_rsp.rvalid)
		else $error("response valid high in the cycle after reset");

endmodule

`default_nettype wire

/* dv/tb_emu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_emu_core;
	import emu_cfg_pkg::*;
	import video_pkg::*;

	localparam int          LED_HOLD     = 20;
	localparam int unsigned GRAV_STEP    = 40_000;
	localparam int          GRAV_CYCLES  = 4_000;
	localparam int          ACCEPT_LIMIT = 20;
	localparam int          RANDOM_MODES = 32;
	localparam int          PAL_WRITES   = 24;
	// Gravis windows dominate and the rest of the tests fit well under 1000 cycles
	localparam int          TEST_CYCLES     = 2 * GRAV_CYCLES + 1_000;
	localparam int          WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 2;

	logic          clk_sys;
	logic          cpu_reset;
	axi_lite_req_t cfg_req;
	axi_lite_rsp_t cfg_rsp;
	vga_mode_t     vga_mode;
	pal_write_t    pal_in;
	fb_pal_t       pal_out;
	fb_desc_t      fb;
	logic          video_f60;
	aspect_t       aspect;
	logic [7:0]    disk_req;
	logic          led_disk;
	logic          led_user;
	logic          joystick_clk_grav;

	integer seed;
	int     checks;
	int     value_errors;
	int     proto_errors;

	// Shadow of the status fields last written
	logic cur_vsync;
	logic cur_rgb;
	logic cur_f565;

	emu_core #(
		.LED_HOLD_CYCLES (LED_HOLD)
	) UUT (
		.clk_sys           (clk_sys),
		.cpu_reset         (cpu_reset),
		.cfg_req           (cfg_req),
		.cfg_rsp           (cfg_rsp),
		.vga_mode          (vga_mode),
		.pal_in            (pal_in),
		.pal_out           (pal_out),
		.fb                (fb),
		.video_f60         (video_f60),
		.aspect            (aspect),
		.disk_req          (disk_req),
		.led_disk          (led_disk),
		.led_user          (led_user),
		.joystick_clk_grav (joystick_clk_grav)
	);

	bind cfg_regs emu_core_assert u_axi_assert (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.cfg_req   (cfg_req),
		.cfg_rsp   (cfg_rsp)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic check_data(input string name, input cfg_data_t got, input cfg_data_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_fb(input string name, input fb_desc_t got, input fb_desc_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_pal(input string name, input fb_pal_t got, input fb_pal_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_aspect(input string name, input aspect_t got, input aspect_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp, input int tol);
		checks++;
		if (got < exp - tol || got > exp + tol) begin
			value_errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic proto_fail(input string msg);
		proto_errors++;
		$display("%s", msg);
	endtask

	// ==================================================
	// Reference rules
	// ==================================================

	function automatic fb_desc_t expected_fb(input vga_mode_t m, input logic f565,
	                                         input logic rgb);
		fb_desc_t   d;
		logic [1:0] depth;
		depth = m.flags[1:0];
		d = '0;
		d.en = !m.flags[2] && (depth != 2'd0);
		d.base = 32'h3F80_0000 | (32'(m.start_addr) << 2);
		if (depth == 2'd3)
			d.width = 12'd640;
		else if (m.flags[2])
			d.width = m.width * 4;
		else
			d.width = m.width * 8;
		d.height = m.flags[3] ? m.height / 2 : m.height;
		d.stride = m.stride * 8;
		case (depth)
			2'd3:    d.format[2:0] = 3'b101;
			2'd2:    d.format[2:0] = 3'b100;
			default: d.format[2:0] = 3'b011;
		endcase
		d.format[3] = !f565;
		d.format[4] = !rgb;
		return d;
	endfunction

	function automatic logic [7:0] widen6(input logic [5:0] c);
		return {c, c[5:4]};
	endfunction

	function automatic longint grav_rate(input logic [2:0] speed);
		case (speed)
			3'd0:    return 90_000_000;
			3'd1:    return 15_000_000;
			3'd2:    return 30_000_000;
			3'd3:    return 56_250_000;
			default: return 100_000_000;
		endcase
	endfunction

	function automatic logic led_of(input logic user);
		return user ? led_user : led_disk;
	endfunction

	// ==================================================
	// AXI4-Lite manager tasks
	// ==================================================

	// While the response is stalled a second request stays pending and must not be taken
	task automatic axi_write(input cfg_addr_t addr, input cfg_data_t data, input logic [3:0] strb,
	                         input int hold, output axi_resp_t resp);
		int waited;
		resp = '0;
		@(negedge clk_sys);
		cfg_req.awvalid = 1'b1;
		cfg_req.awaddr  = addr;
		cfg_req.wvalid  = 1'b1;
		cfg_req.wdata   = data;
		cfg_req.wstrb   = strb;
		cfg_req.bready  = 1'b0;
		#1;
		waited = 0;
		while (!(cfg_rsp.awready && cfg_rsp.wready)) begin
			if (waited == ACCEPT_LIMIT) begin
				proto_fail("The write address and data were never accepted");
				cfg_req.awvalid = 1'b0;
				cfg_req.wvalid  = 1'b0;
				return;
			end
			@(negedge clk_sys);
			#1;
			waited++;
		end
		@(negedge clk_sys);
		if (!cfg_rsp.bvalid)
			proto_fail("bvalid did not rise after the write was accepted");
		resp = cfg_rsp.bresp;
		for (int i = 0; i < hold; i++) begin
			#1;
			check_bit("bvalid", cfg_rsp.bvalid, 1'b1);
			check_bit("awready", cfg_rsp.awready, 1'b0);
			check_bit("wready", cfg_rsp.wready, 1'b0);
			check_resp("bresp", cfg_rsp.bresp, resp);
			@(negedge clk_sys);
		end
		cfg_req.awvalid = 1'b0;
		cfg_req.wvalid  = 1'b0;
		cfg_req.bready  = 1'b1;
		@(negedge clk_sys);
		cfg_req.bready = 1'b0;
		#1;
		check_bit("bvalid", cfg_rsp.bvalid, 1'b0);
	endtask

	task automatic axi_read(input cfg_addr_t addr, input int hold, output cfg_data_t data,
	                        output axi_resp_t resp);
		int waited;
		data = '0;
		resp = '0;
		@(negedge clk_sys);
		cfg_req.arvalid = 1'b1;
		cfg_req.araddr  = addr;
		cfg_req.rready  = 1'b0;
		#1;
		waited = 0;
		while (!cfg_rsp.arready) begin
			if (waited == ACCEPT_LIMIT) begin
				proto_fail("The read address was never accepted");
				cfg_req.arvalid = 1'b0;
				return;
			end
			@(negedge clk_sys);
			#1;
			waited++;
		end
		@(negedge clk_sys);
		if (!cfg_rsp.rvalid)
			proto_fail("rvalid did not rise after the read was accepted");
		data = cfg_rsp.rdata;
		resp = cfg_rsp.rresp;
		for (int i = 0; i < hold; i++) begin
			#1;
			check_bit("rvalid", cfg_rsp.rvalid, 1'b1);
			check_bit("arready", cfg_rsp.arready, 1'b0);
			check_data("rdata", cfg_rsp.rdata, data);
			check_resp("rresp", cfg_rsp.rresp, resp);
			@(negedge clk_sys);
		end
		cfg_req.arvalid = 1'b0;
		cfg_req.rready  = 1'b1;
		@(negedge clk_sys);
		cfg_req.rready = 1'b0;
		#1;
		check_bit("rvalid", cfg_rsp.rvalid, 1'b0);
	endtask

	// Status layout has aspect_wide at bit 1, vsync_variable at 4, speed at 7:5,
	// rgb_order at 8 and format_565 at 9
	task automatic set_status(input logic wide, input logic vsync, input logic [2:0] speed,
	                          input logic rgb, input logic f565);
		axi_resp_t resp;
		cfg_data_t w;
		w = '0;
		w[1]   = wide;
		w[4]   = vsync;
		w[7:5] = speed;
		w[8]   = rgb;
		w[9]   = f565;
		axi_write(STATUS_ADDR, w, 4'hF, 0, resp);
		check_resp("bresp", resp, RESP_OKAY);
		cur_vsync = vsync;
		cur_rgb   = rgb;
		cur_f565  = f565;
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic test_reset();
		cfg_data_t d;
		axi_resp_t resp;
		#1;
		check_fb("fb", fb, '0);
		check_bit("bvalid", cfg_rsp.bvalid, 1'b0);
		check_bit("rvalid", cfg_rsp.rvalid, 1'b0);
		check_bit("awready", cfg_rsp.awready, 1'b0);
		check_bit("arready", cfg_rsp.arready, 1'b0);
		check_bit("led_disk", led_disk, 1'b0);
		check_bit("led_user", led_user, 1'b0);
		check_bit("joystick_clk_grav", joystick_clk_grav, 1'b0);
		check_aspect("aspect", aspect, aspect_t'({8'd4, 8'd3}));
		axi_read(STATUS_ADDR, 0, d, resp);
		check_data("rdata", d, 32'h0);
		check_resp("rresp", resp, RESP_OKAY);
	endtask

	task automatic test_axi();
		cfg_data_t d;
		axi_resp_t resp;
		axi_write(STATUS_ADDR, 32'h1122_3344, 4'hF, 0, resp);
		check_resp("bresp", resp, RESP_OKAY);
		// Strobes 0 and 2 replace bytes 0 and 2 only
		axi_write(STATUS_ADDR, 32'hAABB_CCDD, 4'b0101, 3, resp);
		check_resp("bresp", resp, RESP_OKAY);
		axi_read(STATUS_ADDR, 2, d, resp);
		check_data("rdata", d, 32'h11BB_33DD);
		check_resp("rresp", resp, RESP_OKAY);
		axi_write(4'h4, 32'hFFFF_FFFF, 4'hF, 2, resp);
		check_resp("bresp", resp, RESP_SLVERR);
		axi_read(4'h8, 4, d, resp);
		check_data("rdata", d, 32'h0);
		check_resp("rresp", resp, RESP_SLVERR);
		axi_read(STATUS_ADDR, 0, d, resp);
		check_data("rdata", d, 32'h11BB_33DD);
		check_resp("rresp", resp, RESP_OKAY);
	endtask

	task automatic apply_mode(input vga_mode_t m);
		fb_desc_t exp;
		@(negedge clk_sys);
		vga_mode = m;
		exp = expected_fb(m, cur_f565, cur_rgb);
		@(negedge clk_sys);
		check_fb("fb", fb, exp);
		@(negedge clk_sys);
		check_bit("video_f60", video_f60, exp.en || (exp.width > 12'd760) || !cur_vsync);
	endtask

	task automatic test_fb();
		vga_mode_t   m;
		logic [63:0] r;
		set_status(1'b1, 1'b1, 3'd0, 1'b0, 1'b1);
		check_aspect("aspect", aspect, aspect_t'({8'd16, 8'd9}));
		// 640x480 at 8 bpp, then 24 bpp double scan, planar, text and wide 16 bpp
		m = '0;
		m.start_addr = 20'h0_1234;
		m.width = 9'd80;
		m.stride = 9'd80;
		m.height = 11'd480;
		m.flags = 4'b0001;
		apply_mode(m);
		m.flags = 4'b1011;
		m.height = 11'd400;
		apply_mode(m);
		m.flags = 4'b0101;
		apply_mode(m);
		m.flags = 4'b0000;
		apply_mode(m);
		set_status(1'b0, 1'b0, 3'd0, 1'b1, 1'b0);
		check_aspect("aspect", aspect, aspect_t'({8'd4, 8'd3}));
		m.width = 9'd100;
		m.flags = 4'b0010;
		apply_mode(m);
		for (int i = 0; i < RANDOM_MODES; i++) begin
			if (i % 8 == 0) begin
				r = {$random(seed), $random(seed)};
				set_status(r[0], r[1], 3'd0, r[2], r[3]);
			end
			r = {$random(seed), $random(seed)};
			m = r[53:0];
			apply_mode(m);
		end
	endtask

	task automatic test_palette();
		logic [31:0] r;
		pal_write_t  p;
		fb_pal_t     exp;
		repeat (PAL_WRITES) begin
			r = $random(seed);
			p = r[26:0];
			@(negedge clk_sys);
			pal_in = p;
			#1;
			exp.addr = p.addr;
			exp.we   = p.we;
			exp.data = {widen6(p.data[17:12]), widen6(p.data[11:6]), widen6(p.data[5:0])};
			check_pal("pal_out", pal_out, exp);
		end
		@(negedge clk_sys);
		pal_in = '0;
	endtask

	// A gap of zero sends one request and any other gap sends a second one gap cycles later
	task automatic led_pulse(input int req_bit, input int gap);
		int   delay;
		int   width;
		logic user;
		user = req_bit >= 6;
		@(negedge clk_sys);
		disk_req = 8'(1) << req_bit;
		@(negedge clk_sys);
		disk_req = '0;
		if (gap > 0) begin
			repeat (gap - 1) @(negedge clk_sys);
			disk_req = 8'(1) << req_bit;
			@(negedge clk_sys);
			disk_req = '0;
		end
		delay = 0;
		while (!led_of(user) && delay < 50) begin
			@(negedge clk_sys);
			delay++;
		end
		check_bit(user ? "led_disk" : "led_user", led_of(!user), 1'b0);
		width = 0;
		while (led_of(user) && width < 100) begin
			width++;
			@(negedge clk_sys);
		end
		// After a reload the LED stays lit through the reload cycle and the full hold
		check_count(user ? "led_user delay" : "led_disk delay", delay, gap > 0 ? 0 : 1, 0);
		check_count(user ? "led_user cycles" : "led_disk cycles", width,
		            gap > 0 ? LED_HOLD + 1 : LED_HOLD, 0);
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic test_leds();
		led_pulse(0, 0);
		led_pulse(5, 0);
		led_pulse(6, 0);
		led_pulse(7, 0);
		led_pulse(3, 10);
		led_pulse(7, 12);
	endtask

	task automatic test_gravis();
		int     toggles;
		int     exp;
		logic   prev;
		longint rate;
		for (int s = 1; s <= 2; s++) begin
			set_status(1'b0, 1'b1, 3'(s), 1'b0, 1'b0);
			rate = grav_rate(3'(s));
			exp = int'((longint'(GRAV_STEP) * GRAV_CYCLES) / rate);
			toggles = 0;
			prev = joystick_clk_grav;
			repeat (GRAV_CYCLES) begin
				@(negedge clk_sys);
				if (joystick_clk_grav !== prev)
					toggles++;
				prev = joystick_clk_grav;
			end
			check_count("joystick_clk_grav toggles", toggles, exp, 1);
		end
	endtask

	// ==================================================
	// Main sequence and watchdog
	// ==================================================

	initial begin
		seed         = 32'hc1a09dc3;
		checks       = 0;
		value_errors = 0;
		proto_errors = 0;
		cur_vsync    = 1'b0;
		cur_rgb      = 1'b0;
		cur_f565     = 1'b0;
		cpu_reset    = 1'b1;
		cfg_req      = '0;
		vga_mode     = '0;
		pal_in       = '0;
		disk_req     = '0;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		cpu_reset = 1'b0;
		test_reset();
		test_axi();
		test_fb();
		test_palette();
		test_leds();
		test_gravis();
		$display("Checks: %0d, value errors: %0d, protocol errors: %0d",
		         checks, value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks: %0d, value errors: %0d, protocol errors: %0d",
		         checks, value_errors, proto_errors);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
verilog/emu_cfg_pkg.sv
verilog/video_pkg.sv
verilog/cfg_regs.sv
verilog/fb_descriptor.sv
verilog/activity_led.sv
verilog/gravis_clock.sv
verilog/emu_core.sv
dv/emu_core_assert.sv
dv/tb_emu_core.sv

/* verilog/activity_led.sv */
`timescale 1ns/1ps
`default_nettype none

module activity_led #(
	parameter int REQ_BITS    = 1,
	parameter int HOLD_CYCLES = 4_500_000
) (
	input  logic                clk_sys,
	input  logic                cpu_reset,
	input  logic [REQ_BITS-1:0] req,
	output logic                led
);
	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	logic [CNT_W-1:0] hold_cnt;

	// Any request reloads the full hold time
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			hold_cnt <= '0;
			led      <= 1'b0;
		end else begin
			led <= hold_cnt != '0;
			if (|req) begin
				hold_cnt <= CNT_W'(HOLD_CYCLES);
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
	input  logic                       clk_sys,
	input  logic                       cpu_reset,
	input  emu_cfg_pkg::axi_lite_req_t cfg_req,
	output emu_cfg_pkg::axi_lite_rsp_t cfg_rsp,
	output emu_cfg_pkg::emu_status_t   status
);
	import emu_cfg_pkg::*;

	emu_status_t status_q;
	cfg_data_t   status_next;

	logic      bvalid_q;
	axi_resp_t bresp_q;
	logic      rvalid_q;
	cfg_data_t rdata_q;
	axi_resp_t rresp_q;

	logic wr_accept;
	logic rd_accept;
	logic wr_hit;
	logic rd_hit;

	// Accept only while no response of the same kind is outstanding
	assign wr_accept = cfg_req.awvalid && cfg_req.wvalid && !bvalid_q;
	assign rd_accept = cfg_req.arvalid && !rvalid_q;
	assign wr_hit    = cfg_req.awaddr == STATUS_ADDR;
	assign rd_hit    = cfg_req.araddr == STATUS_ADDR;

	// Byte lane merge
	always_comb begin
		status_next = status_q;
		for (int i = 0; i < 4; i++) begin
			if (cfg_req.wstrb[i]) begin
				status_next[8*i +: 8] = cfg_req.wdata[8*i +: 8];
			end
		end
	end

	// ================================================
	// Write channel
	// ================================================

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			status_q <= '0;
			bvalid_q <= 1'b0;
		end else if (wr_accept) begin
			bvalid_q <= 1'b1;
			if (wr_hit) begin
				status_q <= emu_status_t'(status_next);
			end
		end else if (bvalid_q && cfg_req.bready) begin
			bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_accept) begin
			bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// ================================================
	// Read channel
	// ================================================

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			rvalid_q <= 1'b0;
		end else if (rd_accept) begin
			rvalid_q <= 1'b1;
		end else if (rvalid_q && cfg_req.rready) begin
			rvalid_q <= 1'b0;
		end
	end

	// Unmapped reads return zero
	always_ff @(posedge clk_sys) begin
		if (rd_accept) begin
			rdata_q <= rd_hit ? cfg_data_t'(status_q) : '0;
			rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

	assign cfg_rsp.awready = wr_accept;
	assign cfg_rsp.wready  = wr_accept;
	assign cfg_rsp.bvalid  = bvalid_q;
	assign cfg_rsp.bresp   = bresp_q;
	assign cfg_rsp.arready = rd_accept;
	assign cfg_rsp.rvalid  = rvalid_q;
	assign cfg_rsp.rdata   = rdata_q;
	assign cfg_rsp.rresp   = rresp_q;

	assign status = status_q;

endmodule

`default_nettype wire

/* verilog/emu_cfg_pkg.sv */
`default_nettype none

package emu_cfg_pkg;

	// ================================================
	// AXI4-Lite configuration port
	// ================================================

	typedef logic [3:0]  cfg_addr_t;
	typedef logic [31:0] cfg_data_t;
	typedef logic [3:0]  cfg_strb_t;
	typedef logic [1:0]  axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// Channels driven by the manager
	typedef struct packed {
		logic      awvalid;
		cfg_addr_t awaddr;
		logic      wvalid;
		cfg_data_t wdata;
		cfg_strb_t wstrb;
		logic      bready;
		logic      arvalid;
		cfg_addr_t araddr;
		logic      rready;
	} axi_lite_req_t;

	// Channels driven by the subordinate
	typedef struct packed {
		logic      awready;
		logic      wready;
		logic      bvalid;
		axi_resp_t bresp;
		logic      arready;
		logic      rvalid;
		cfg_data_t rdata;
		axi_resp_t rresp;
	} axi_lite_rsp_t;

	// ================================================
	// Status word
	// ================================================

	typedef logic [2:0] cpu_speed_t;

	// Packed from the top, so reset_req sits at bit 0
	typedef struct packed {
		logic [21:0] spare;
		logic        format_565;
		logic        rgb_order;
		cpu_speed_t  speed;
		logic        vsync_variable;
		logic [1:0]  unused;
		logic        aspect_wide;
		logic        reset_req;
	} emu_status_t;

	localparam cfg_addr_t STATUS_ADDR = 4'h0;

	// CPU clock rate per speed setting, in Hz
	typedef logic [27:0] clk_rate_t;

	localparam clk_rate_t CLK_RATE_TABLE [0:7] = '{
		28'd90_000_000, 28'd15_000_000, 28'd30_000_000, 28'd56_250_000,
		28'd100_000_000, 28'd100_000_000, 28'd100_000_000, 28'd100_000_000
	};

endpackage

`default_nettype wire

/* verilog/emu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module emu_core #(
	parameter int          LED_HOLD_CYCLES = 4_500_000,
	parameter int unsigned GRAV_STEP       = 40_000
) (
	input  logic                       clk_sys,
	input  logic                       cpu_reset,
	input  emu_cfg_pkg::axi_lite_req_t cfg_req,
	output emu_cfg_pkg::axi_lite_rsp_t cfg_rsp,
	input  video_pkg::vga_mode_t       vga_mode,
	input  video_pkg::pal_write_t      pal_in,
	output video_pkg::fb_pal_t         pal_out,
	output video_pkg::fb_desc_t        fb,
	output logic                       video_f60,
	output video_pkg::aspect_t         aspect,
	input  logic [7:0]                 disk_req,
	output logic                       led_disk,
	output logic                       led_user,
	output logic                       joystick_clk_grav
);
	import emu_cfg_pkg::*;

	emu_status_t status;

	cfg_regs u_cfg_regs (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.cfg_req   (cfg_req),
		.cfg_rsp   (cfg_rsp),
		.status    (status)
	);

	fb_descriptor u_fb_descriptor (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.status    (status),
		.vga_mode  (vga_mode),
		.pal_in    (pal_in),
		.fb        (fb),
		.pal_out   (pal_out),
		.video_f60 (video_f60),
		.aspect    (aspect)
	);

	gravis_clock #(
		.GRAV_STEP (GRAV_STEP)
	) u_gravis_clock (
		.clk_sys           (clk_sys),
		.cpu_reset         (cpu_reset),
		.status            (status),
		.joystick_clk_grav (joystick_clk_grav)
	);

	// Hard disk requests occupy bits 5:0, floppy bits 7:6
	activity_led #(
		.REQ_BITS    (6),
		.HOLD_CYCLES (LED_HOLD_CYCLES)
	) hdd_led (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.req       (disk_req[5:0]),
		.led       (led_disk)
	);

	activity_led #(
		.REQ_BITS    (2),
		.HOLD_CYCLES (LED_HOLD_CYCLES)
	) fdd_led (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.req       (disk_req[7:6]),
		.led       (led_user)
	);

endmodule

`default_nettype wire

/* verilog/fb_descriptor.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_descriptor (
	input  logic                     clk_sys,
	input  logic                     cpu_reset,
	input  emu_cfg_pkg::emu_status_t status,
	input  video_pkg::vga_mode_t     vga_mode,
	input  video_pkg::pal_write_t    pal_in,
	output video_pkg::fb_desc_t      fb,
	output video_pkg::fb_pal_t       pal_out,
	output logic                     video_f60,
	output video_pkg::aspect_t       aspect
);
	import video_pkg::*;

	vga_depth_t depth;
	logic       planar;
	logic       dscan;
	fb_desc_t   fb_next;
	fb_desc_t   fb_q;
	logic       f60_q;

	assign depth  = vga_mode.flags[1:0];
	assign planar = vga_mode.flags[2];
	assign dscan  = vga_mode.flags[3];

	// ================================================
	// Descriptor from the current video mode
	// ================================================

	always_comb begin
		fb_next.en   = !planar && (depth != 2'd0);
		fb_next.base = {4'h3, 6'b111110, vga_mode.start_addr, 2'b00};

		// 24 bpp is always shown 640 wide
		if (depth == 2'd3) begin
			fb_next.width = 12'd640;
		end else if (planar) begin
			fb_next.width = {1'b0, vga_mode.width, 2'b00};
		end else begin
			fb_next.width = {vga_mode.width, 3'b000};
		end

		fb_next.height = dscan ? {2'b00, vga_mode.height[10:1]} : {1'b0, vga_mode.height};
		fb_next.stride = {2'b00, vga_mode.stride, 3'b000};

		case (depth)
			2'd3:    fb_next.format[2:0] = FMT_24BPP;
			2'd2:    fb_next.format[2:0] = FMT_16BPP;
			default: fb_next.format[2:0] = FMT_8BPP_PAL;
		endcase
		fb_next.format[3] = !status.format_565;
		fb_next.format[4] = !status.rgb_order;

		fb_next.force_blank = 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			fb_q  <= '0;
			f60_q <= 1'b0;
		end else begin
			fb_q  <= fb_next;
			f60_q <= fb_q.en || (fb_q.width > fb_dim_t'(760));
		end
	end

	assign fb        = fb_q;
	assign video_f60 = f60_q || !status.vsync_variable;

	assign aspect.arx = status.aspect_wide ? 8'd16 : 8'd4;
	assign aspect.ary = status.aspect_wide ? 8'd9 : 8'd3;

	// Widen 6 bit channels by repeating their top bits
	assign pal_out.addr = pal_in.addr;
	assign pal_out.we   = pal_in.we;
	assign pal_out.data = {pal_in.data[17:12], pal_in.data[17:16],
	                       pal_in.data[11:6], pal_in.data[11:10],
	                       pal_in.data[5:0], pal_in.data[5:4]};

endmodule

`default_nettype wire

/* verilog/gravis_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module gravis_clock #(
	parameter int unsigned GRAV_STEP = 40_000
) (
	input  logic                     clk_sys,
	input  logic                     cpu_reset,
	input  emu_cfg_pkg::emu_status_t status,
	output logic                     joystick_clk_grav
);
	import emu_cfg_pkg::*;

	clk_rate_t   cur_rate;
	logic [31:0] rate_ext;
	logic [31:0] acc;
	logic [31:0] sum;

	assign cur_rate = CLK_RATE_TABLE[status.speed];
	assign rate_ext = {4'b0000, cur_rate};
	assign sum      = acc + 32'(GRAV_STEP);

	// Phase accumulator whose output toggles on each wrap past the rate
	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			acc               <= '0;
			joystick_clk_grav <= 1'b0;
		end else if (sum >= rate_ext) begin
			acc               <= sum - rate_ext;
			joystick_clk_grav <= !joystick_clk_grav;
		end else begin
			acc <= sum;
		end
	end

endmodule

`default_nettype wire

/* verilog/video_pkg.sv */
`default_nettype none

package video_pkg;

	// ================================================
	// Video mode reported by the PC core
	// ================================================

	// Bits 1:0 depth code, bit 2 planar, bit 3 double scan
	typedef logic [3:0] vga_flags_t;
	typedef logic [1:0] vga_depth_t;

	typedef struct packed {
		logic [19:0] start_addr;
		logic [8:0]  width;
		logic [8:0]  stride;
		logic [10:0] height;
		vga_flags_t  flags;
		logic        off;
	} vga_mode_t;

	// ================================================
	// Framebuffer descriptor
	// ================================================

	typedef logic [11:0] fb_dim_t;
	typedef logic [13:0] fb_stride_t;
	typedef logic [31:0] fb_addr_t;
	typedef logic [4:0]  fb_format_t;

	// Low three bits of the format field
	localparam logic [2:0] FMT_8BPP_PAL = 3'b011;
	localparam logic [2:0] FMT_16BPP    = 3'b100;
	localparam logic [2:0] FMT_24BPP    = 3'b101;

	typedef struct packed {
		logic       en;
		fb_format_t format;
		fb_dim_t    width;
		fb_dim_t    height;
		fb_addr_t   base;
		fb_stride_t stride;
		logic       force_blank;
	} fb_desc_t;

	// Palette write from the VGA block, 6 bits per channel, red highest
	typedef struct packed {
		logic [7:0]  addr;
		logic [17:0] data;
		logic        we;
	} pal_write_t;

	typedef struct packed {
		logic [7:0]  addr;
		logic [23:0] data;
		logic        we;
	} fb_pal_t;

	typedef struct packed {
		logic [7:0] arx;
		logic [7:0] ary;
	} aspect_t;

endpackage

`default_nettype wire
